//--- source/iadc_consts.svh
`ifndef IADC_CONSTS_SVH
`define IADC_CONSTS_SVH

// serial configuration port fields
`define IADC_TWI_ADDR_W 3
`define IADC_TWI_DATA_W 16

// bus clocks per serial bit = 2**IADC_TWI_DIV_W
`define IADC_TWI_DIV_W 7

// capture fifo holds 2**IADC_FIFO_AW samples
`define IADC_FIFO_AW 4

// entries of margin for almost_full and almost_empty
`define IADC_FIFO_ALMOST 2

// raw adc word layout
`define IADC_SYNC_W 4
`define IADC_OOR_W 4
`define IADC_DATA_W 64

// wishbone data width
`define IADC_WB_DW 16

`endif

//--- source/iadc_pkg.sv
`default_nettype none

`include "iadc_consts.svh"

package iadc_pkg;

  // register index, taken from wb_adr_i[4:1]
  typedef enum logic [3:0] {
    REG_RESET       = 4'd0,
    REG_MODE        = 4'd1,
    REG_TWI_ADDR    = 4'd2,
    REG_TWI_DATA    = 4'd3,
    REG_TWI_TX      = 4'd4,
    REG_FIFODATA_4  = 4'd5,  // sync and out-of-range bits
    REG_FIFODATA_3  = 4'd6,
    REG_FIFODATA_2  = 4'd7,
    REG_FIFODATA_1  = 4'd8,
    REG_FIFODATA_0  = 4'd9,
    REG_FIFO_ADV    = 4'd10,
    REG_FIFO_STATUS = 4'd11,
    REG_FIFO_CTRL   = 4'd12
  } reg_idx_e;

  typedef enum logic [2:0] {
    TWI_IDLE,
    TWI_ALIGN,   // wait for a falling sclk so the first bit gets a full period
    TWI_SHIFT,
    TWI_COMMIT,  // one extra clock with strobe still low
    TWI_RELEASE
  } twi_state_e;

  typedef struct packed {
    logic [`IADC_TWI_ADDR_W-1:0] addr;  // sent first
    logic [`IADC_TWI_DATA_W-1:0] data;
  } twi_cmd_t;

  typedef struct packed {
    logic [`IADC_SYNC_W-1:0] sync;  // four phase samples of the sync pin
    logic [`IADC_OOR_W-1:0]  oor;
    logic [`IADC_DATA_W-1:0] data;
  } adc_sample_t;

  typedef struct packed {
    logic full;
    logic almost_full;
    logic almost_empty;
    logic empty;
  } fifo_status_t;

endpackage

`default_nettype wire

//--- source/iadc_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "iadc_consts.svh"

module iadc_regs (
  input  wire                        wb_clk_i,
  input  wire                        wb_rst_i,
  input  wire                        wb_cyc_i,
  input  wire                        wb_stb_i,
  input  wire                        wb_we_i,
  input  wire [1:0]                  wb_sel_i,
  input  wire [31:0]                 wb_adr_i,
  input  wire [`IADC_WB_DW-1:0]      wb_dat_i,
  output logic [`IADC_WB_DW-1:0]     wb_dat_o,
  output logic                       wb_ack_o,
  input  wire                        busy_i,
  input  iadc_pkg::adc_sample_t      head_i,
  input  iadc_pkg::fifo_status_t     status_i,
  output iadc_pkg::twi_cmd_t         twi_cmd_o,
  output logic                       tx_stb_o,
  output logic                       pop_o,
  output logic                       cap_en_o,
  output logic                       cap_clear_o,
  output logic                       adc_mode_o,
  output logic                       adc_ddrb_o
);

  localparam int DW = `IADC_WB_DW;

  logic                req;
  iadc_pkg::reg_idx_e  wr_idx;
  iadc_pkg::reg_idx_e  rd_idx;   // latched for the read mux
  logic                cap_en_d; // previous enable, for edge detect

  assign req    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_idx = iadc_pkg::reg_idx_e'(wb_adr_i[4:1]);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o       <= 1'b0;
      rd_idx         <= iadc_pkg::REG_RESET;
      twi_cmd_o      <= '0;
      tx_stb_o       <= 1'b0;
      pop_o          <= 1'b0;
      cap_en_o       <= 1'b0;
      cap_en_d       <= 1'b0;
      adc_mode_o     <= 1'b0;
      adc_ddrb_o     <= 1'b0;
    end else begin
      wb_ack_o   <= req;
      cap_en_d   <= cap_en_o;
      // pulses default low
      tx_stb_o   <= 1'b0;
      pop_o      <= 1'b0;
      adc_ddrb_o <= 1'b0;

      if (req) begin
        rd_idx <= wr_idx;
        if (wb_we_i) begin
          case (wr_idx)
            iadc_pkg::REG_RESET: begin
              if (wb_sel_i[0])
                adc_ddrb_o <= wb_dat_i[0]; // one clock reset pulse to the adc
            end
            iadc_pkg::REG_MODE: begin
              if (wb_sel_i[0])
                adc_mode_o <= wb_dat_i[0];
            end
            iadc_pkg::REG_TWI_ADDR: begin
              if (wb_sel_i[0])
                twi_cmd_o.addr <= wb_dat_i[`IADC_TWI_ADDR_W-1:0];
            end
            iadc_pkg::REG_TWI_DATA: begin
              if (wb_sel_i[1])
                twi_cmd_o.data[15:8] <= wb_dat_i[15:8];
              if (wb_sel_i[0])
                twi_cmd_o.data[7:0] <= wb_dat_i[7:0];
            end
            iadc_pkg::REG_TWI_TX: begin
              if (wb_sel_i[0])
                tx_stb_o <= wb_dat_i[0]; // restarts a transfer in flight
            end
            iadc_pkg::REG_FIFO_ADV: begin
              if (wb_sel_i[0])
                pop_o <= wb_dat_i[0];
            end
            iadc_pkg::REG_FIFO_CTRL: begin
              if (wb_sel_i[0])
                cap_en_o <= wb_dat_i[0];
            end
            default: begin
              // data slices and status are read only
            end
          endcase
        end
      end
    end
  end

  // discard stale samples each time capture is switched on
  assign cap_clear_o = cap_en_o & ~cap_en_d;

  always_comb begin
    case (rd_idx)
      iadc_pkg::REG_RESET:       wb_dat_o = DW'(adc_ddrb_o);
      iadc_pkg::REG_MODE:        wb_dat_o = DW'(adc_mode_o);
      iadc_pkg::REG_TWI_ADDR:    wb_dat_o = DW'(twi_cmd_o.addr);
      iadc_pkg::REG_TWI_DATA:    wb_dat_o = twi_cmd_o.data;
      iadc_pkg::REG_TWI_TX:      wb_dat_o = DW'(busy_i);
      iadc_pkg::REG_FIFODATA_4:  wb_dat_o = DW'({head_i.sync, head_i.oor});
      iadc_pkg::REG_FIFODATA_3:  wb_dat_o = head_i.data[63:48];
      iadc_pkg::REG_FIFODATA_2:  wb_dat_o = head_i.data[47:32];
      iadc_pkg::REG_FIFODATA_1:  wb_dat_o = head_i.data[31:16];
      iadc_pkg::REG_FIFODATA_0:  wb_dat_o = head_i.data[15:0];
      iadc_pkg::REG_FIFO_STATUS: wb_dat_o = DW'(status_i);
      iadc_pkg::REG_FIFO_CTRL:   wb_dat_o = DW'(cap_en_o);
      default:                   wb_dat_o = '0; // includes REG_FIFO_ADV
    endcase
  end

  // every request gets exactly one ack clock
  a_ack_single: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o
  );

endmodule

`default_nettype wire

//--- source/twi_clk_div.sv
`default_nettype none
`timescale 1ns/1ps

`include "iadc_consts.svh"

module twi_clk_div (
  input  wire  wb_clk_i,
  input  wire  wb_rst_i,
  output logic sclk_o,
  output logic tick_o
);

  localparam int DIV_W = `IADC_TWI_DIV_W;

  logic [DIV_W-1:0] div_q;

  // free running, never held by a transfer
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  assign sclk_o = div_q[DIV_W-1];
  assign tick_o = &div_q; // next edge wraps, sclk falls there

endmodule

`default_nettype wire

//--- source/twi_fsm.sv
`default_nettype none
`timescale 1ns/1ps

module twi_fsm (
  input  wire                 wb_clk_i,
  input  wire                 wb_rst_i,
  input  wire                 tick_i,
  input  wire                 sclk_i,
  input  wire                 tx_stb_i,
  input  iadc_pkg::twi_cmd_t  cmd_i,
  output logic                busy_o,
  output logic                ctrl_clk_o,
  output logic                ctrl_data_o,
  output logic                ctrl_strobe_n_o
);

  localparam int CMD_W = $bits(iadc_pkg::twi_cmd_t);

  iadc_pkg::twi_state_e state_q;
  logic [4:0]           bit_cnt_q;
  logic [CMD_W-1:0]     shift_q;   // address bits on top, msb out first

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= iadc_pkg::TWI_IDLE;
      bit_cnt_q <= '0;
      shift_q   <= '0;
    end else if (tx_stb_i) begin
      state_q   <= iadc_pkg::TWI_ALIGN;
      bit_cnt_q <= '0;
      shift_q   <= cmd_i;
    end else if (tick_i) begin
      case (state_q)
        iadc_pkg::TWI_ALIGN: begin
          state_q   <= iadc_pkg::TWI_SHIFT;
          bit_cnt_q <= '0;
        end
        iadc_pkg::TWI_SHIFT: begin
          shift_q   <= {shift_q[CMD_W-2:0], 1'b0};
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (bit_cnt_q == 5'(CMD_W - 1))
            state_q <= iadc_pkg::TWI_COMMIT; // last bit shifted out
        end
        iadc_pkg::TWI_COMMIT: begin
          state_q <= iadc_pkg::TWI_RELEASE;
        end
        iadc_pkg::TWI_RELEASE: begin
          state_q <= iadc_pkg::TWI_IDLE;
        end
        default: begin
          state_q <= iadc_pkg::TWI_IDLE;
        end
      endcase
    end
  end

  assign busy_o      = (state_q != iadc_pkg::TWI_IDLE);
  assign ctrl_data_o = shift_q[CMD_W-1];

  // strobe low from align through commit
  assign ctrl_strobe_n_o = !((state_q == iadc_pkg::TWI_ALIGN) ||
                             (state_q == iadc_pkg::TWI_SHIFT) ||
                             (state_q == iadc_pkg::TWI_COMMIT));

  // clock parked high outside the bit phases
  assign ctrl_clk_o = ((state_q == iadc_pkg::TWI_SHIFT)  ||
                       (state_q == iadc_pkg::TWI_COMMIT) ||
                       (state_q == iadc_pkg::TWI_RELEASE)) ? sclk_i : 1'b1;

  // idle pins parked, and every bit of the last word has been shifted out
  a_idle_pins: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (state_q == iadc_pkg::TWI_IDLE) |-> (ctrl_strobe_n_o && ctrl_clk_o && !ctrl_data_o)
  );

endmodule

`default_nettype wire

//--- source/capture_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "iadc_consts.svh"

module capture_fifo (
  input  wire                     wb_clk_i,
  input  wire                     wb_rst_i,
  input  wire                     adc_clk_i,
  input  iadc_pkg::adc_sample_t   wr_data_i,
  input  wire                     en_i,
  input  wire                     clear_i,
  input  wire                     pop_i,
  output iadc_pkg::adc_sample_t   head_o,
  output iadc_pkg::fifo_status_t  status_o
);

  localparam int AW     = `IADC_FIFO_AW;
  localparam int PTR_W  = AW + 1;  // extra bit tells full from empty
  localparam int DEPTH  = 1 << AW;
  localparam int ALMOST = `IADC_FIFO_ALMOST;

  function automatic logic [PTR_W-1:0] bin2gray(input logic [PTR_W-1:0] b);
    return b ^ (b >> 1);
  endfunction

  function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] g);
    logic [PTR_W-1:0] b;
    b[PTR_W-1] = g[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  iadc_pkg::adc_sample_t mem [DEPTH];

  // adc clock domain
  logic             rst_meta, wr_rst;   // wb reset brought over
  logic             en_meta, en_sync;
  logic [PTR_W-1:0] wr_bin, wr_gray;
  logic [PTR_W-1:0] rd_gray_meta, rd_gray_sync;
  logic             wr_full, wr_en;

  // wb clock domain
  logic [PTR_W-1:0] wr_gray_meta, wr_gray_sync, wr_bin_sync;
  logic [PTR_W-1:0] rd_bin, rd_gray, level;

  always_ff @(posedge adc_clk_i) begin
    rst_meta <= wb_rst_i;
    wr_rst   <= rst_meta;
  end

  assign wr_full = (wr_gray == {~rd_gray_sync[PTR_W-1:PTR_W-2], rd_gray_sync[PTR_W-3:0]});
  assign wr_en   = en_sync & ~wr_full; // samples are dropped while full

  always_ff @(posedge adc_clk_i) begin
    if (wr_rst) begin
      en_meta      <= 1'b0;
      en_sync      <= 1'b0;
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
      wr_bin       <= '0;
      wr_gray      <= '0;
    end else begin
      en_meta      <= en_i;
      en_sync      <= en_meta;
      rd_gray_meta <= rd_gray;
      rd_gray_sync <= rd_gray_meta;
      if (wr_en) begin
        wr_bin  <= wr_bin + 1'b1;
        wr_gray <= bin2gray(wr_bin + 1'b1);
      end
    end
  end

  always_ff @(posedge adc_clk_i) begin
    if (wr_en)
      mem[wr_bin[AW-1:0]] <= wr_data_i;
  end

  assign wr_bin_sync = gray2bin(wr_gray_sync);
  assign level       = wr_bin_sync - rd_bin;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
      rd_bin       <= '0;
      rd_gray      <= '0;
    end else begin
      wr_gray_meta <= wr_gray;
      wr_gray_sync <= wr_gray_meta;
      if (clear_i) begin
        rd_bin  <= wr_bin_sync; // skip whatever is already stored
        rd_gray <= wr_gray_sync;
      end else if (pop_i && !status_o.empty) begin
        rd_bin  <= rd_bin + 1'b1;
        rd_gray <= bin2gray(rd_bin + 1'b1);
      end
    end
  end

  assign head_o = mem[rd_bin[AW-1:0]]; // fall through

  assign status_o.empty        = (level == '0);
  assign status_o.full         = (level == PTR_W'(DEPTH));
  assign status_o.almost_empty = (level <= PTR_W'(ALMOST));
  assign status_o.almost_full  = (level >= PTR_W'(DEPTH - ALMOST));

  // a write only lands while the binary write side level is below the depth
  a_no_write_full: assert property (
    @(posedge adc_clk_i) disable iff (wr_rst)
    wr_en |-> (PTR_W'(wr_bin - gray2bin(rd_gray_sync)) < PTR_W'(DEPTH))
  );

endmodule

`default_nettype wire

//--- source/iadc_top.sv
`default_nettype none
`timescale 1ns/1ps

module iadc_top (
  // wishbone
  input  wire         wb_clk_i,
  input  wire         wb_rst_i,
  input  wire         wb_cyc_i,
  input  wire         wb_stb_i,
  input  wire         wb_we_i,
  input  wire  [1:0]  wb_sel_i,
  input  wire  [31:0] wb_adr_i,
  input  wire  [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  // adc sample side
  input  wire         adc_clk_i,
  input  wire  [63:0] adc_data_i,
  input  wire  [3:0]  adc_oor_i,
  input  wire  [3:0]  adc_sync_i,  // already split into four phases by the pads
  // adc control pins
  output logic        adc_mode_o,
  output logic        adc_ddrb_o,
  output logic        adc_ctrl_clk_o,
  output logic        adc_ctrl_data_o,
  output logic        adc_ctrl_strobe_n_o
);

  iadc_pkg::twi_cmd_t     twi_cmd;
  iadc_pkg::adc_sample_t  sample, head;
  iadc_pkg::fifo_status_t status;
  logic tx_stb, busy, sclk, tick;
  logic cap_en, cap_clear, pop;

  assign sample.sync = adc_sync_i;
  assign sample.oor  = adc_oor_i;
  assign sample.data = adc_data_i;

  iadc_regs regs_i (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
    .wb_sel_i(wb_sel_i), .wb_adr_i(wb_adr_i),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
    .busy_i(busy), .head_i(head), .status_i(status),
    .twi_cmd_o(twi_cmd), .tx_stb_o(tx_stb), .pop_o(pop),
    .cap_en_o(cap_en), .cap_clear_o(cap_clear),
    .adc_mode_o(adc_mode_o), .adc_ddrb_o(adc_ddrb_o)
  );

  twi_clk_div clk_div_i (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .sclk_o(sclk), .tick_o(tick)
  );

  twi_fsm twi_i (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i),
    .tick_i(tick), .sclk_i(sclk), .tx_stb_i(tx_stb), .cmd_i(twi_cmd),
    .busy_o(busy), .ctrl_clk_o(adc_ctrl_clk_o),
    .ctrl_data_o(adc_ctrl_data_o), .ctrl_strobe_n_o(adc_ctrl_strobe_n_o)
  );

  capture_fifo fifo_i (
    .wb_clk_i(wb_clk_i), .wb_rst_i(wb_rst_i), .adc_clk_i(adc_clk_i),
    .wr_data_i(sample), .en_i(cap_en), .clear_i(cap_clear), .pop_i(pop),
    .head_o(head), .status_o(status)
  );

endmodule

`default_nettype wire

//--- tests/tb_iadc_ref.svh
`ifndef TB_IADC_REF_SVH
`define TB_IADC_REF_SVH

localparam logic [15:0] LFSR_SEED = 16'd41577;

// fibonacci lfsr, taps 16 14 13 11
function automatic logic step_lfsr(inout logic [15:0] s);
  logic fb;
  fb = s[15] ^ s[13] ^ s[12] ^ s[10];
  s  = {s[14:0], fb};
  return fb;
endfunction

function automatic logic [31:0] take_bits(inout logic [15:0] s, input int nbits);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < nbits; i++) begin
    v = {v[30:0], step_lfsr(s)}; // one step per bit
  end
  return v;
endfunction

// adc word for sample number n, with n itself in the top data bits
function automatic iadc_pkg::adc_sample_t ref_sample(input logic [31:0] n);
  logic [15:0]           s;
  logic [15:0]           r;
  iadc_pkg::adc_sample_t w;
  s = LFSR_SEED ^ {n[7:0], n[15:8]};
  if (s == '0)
    s = LFSR_SEED;        // an all zero lfsr never moves
  r = 16'(take_bits(s, 16));
  w.sync = n[3:0];
  w.oor  = r[15:12];
  w.data = {n, r, r ^ n[15:0]};
  return w;
endfunction

// bits on the pins while strobe is low: address then data, msb first, then a zero
function automatic logic [19:0] twi_expect(input iadc_pkg::twi_cmd_t cmd);
  return {cmd.addr, cmd.data, 1'b0};
endfunction

// byte lanes whose select bit is low keep their old value
function automatic logic [15:0] merge_write(input logic [15:0] old_v, input logic [15:0] new_v,
                                            input logic [1:0] sel, input logic [15:0] mask);
  logic [15:0] lanes;
  lanes = {{8{sel[1]}}, {8{sel[0]}}};
  return ((old_v & ~lanes) | (new_v & lanes)) & mask;
endfunction

function automatic logic [15:0] field_mask(input iadc_pkg::reg_idx_e idx);
  case (idx)
    iadc_pkg::REG_TWI_ADDR: return 16'h0007;
    iadc_pkg::REG_TWI_DATA: return 16'hffff;
    default:                return 16'h0001; // mode and fifo ctrl are one bit
  endcase
endfunction

`endif

//--- tests/tb_iadc.sv
`default_nettype none
`timescale 1ns/1ps

`include "iadc_consts.svh"

module tb_iadc;

  localparam int BIT_CLKS  = 1 << `IADC_TWI_DIV_W;
  localparam int DEPTH     = 1 << `IADC_FIFO_AW;
  localparam int TWI_NS    = 3 * 22 * BIT_CLKS * 4; // three transfers of 22 bits
  localparam int BUDGET_NS = 1000 + 500 + TWI_NS + 2000 + 2000;

  logic        wb_clk_i = 1'b0;
  logic        adc_clk_i = 1'b0;
  logic        wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i;
  logic [1:0]  wb_sel_i;
  logic [31:0] wb_adr_i;
  logic [15:0] wb_dat_i, wb_dat_o;
  logic        wb_ack_o;
  logic [63:0] adc_data_i;
  logic [3:0]  adc_oor_i, adc_sync_i;
  logic        adc_mode_o, adc_ddrb_o;
  logic        adc_ctrl_clk_o, adc_ctrl_data_o, adc_ctrl_strobe_n_o;

  logic [15:0]        rng;               // stimulus lfsr
  logic [31:0]        n = '0;            // current adc sample number
  logic               ddrb_at_ack;
  int                 ddrb_clocks;
  logic               twi_bits_q[$];
  iadc_pkg::reg_idx_e rw_regs [4];
  string              test_name;
  int                 test_errs, checks, fails;

  `include "tb_iadc_ref.svh"

  iadc_top iadc_top_i (.*);

  always #2 wb_clk_i = ~wb_clk_i;
  always #3 adc_clk_i = ~adc_clk_i;

  // one new sample per adc clock
  always @(negedge adc_clk_i) begin
    n <= n + 1;
    {adc_sync_i, adc_oor_i, adc_data_i} <= ref_sample(n + 1);
  end

  // serial monitor
  always @(posedge adc_ctrl_clk_o) begin
    if (adc_ctrl_strobe_n_o === 1'b0)
      twi_bits_q.push_back(adc_ctrl_data_o);
  end

  always @(negedge wb_clk_i) begin
    if (adc_ddrb_o === 1'b1)
      ddrb_clocks++;
  end

  initial begin
    #(BUDGET_NS * 3 / 2);
    $display("watchdog: run went past %0d ns, a test is stuck", BUDGET_NS * 3 / 2);
    $display("Result: FAILED");
    $finish;
  end

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0)
      $display("test %s: ok", test_name);
    else
      $display("test %s: %0d errors", test_name, test_errs);
  endtask

  task automatic log_mismatch(input logic [79:0] exp, input logic [79:0] act);
    $display("** Error %s: expected %0h actual %0h", test_name, exp, act);
    test_errs++;
    fails++;
  endtask

  task automatic log_failure(input string what);
    $display("%s failed: %s", test_name, what);
    checks++;
    test_errs++;
    fails++;
  endtask

  // called on a falling edge, returns on the falling edge that shows ack
  task automatic bus_cycle(input logic we, input iadc_pkg::reg_idx_e idx,
                           input logic [15:0] dat, input logic [1:0] sel,
                           output logic [15:0] rdat);
    int waited;
    waited   = 0;
    rdat     = '0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = {27'd0, idx, 1'b0};
    wb_dat_i = dat;
    wb_sel_i = sel;
    @(negedge wb_clk_i);
    while (wb_ack_o !== 1'b1 && waited < 8) begin
      waited++;
      @(negedge wb_clk_i);
    end
    if (wb_ack_o === 1'b1) begin
      rdat        = wb_dat_o;
      ddrb_at_ack = adc_ddrb_o;
    end else begin
      log_failure("bus slave never acked");
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input iadc_pkg::reg_idx_e idx, input logic [15:0] dat,
                          input logic [1:0] sel);
    logic [15:0] ignored;
    bus_cycle(1'b1, idx, dat, sel, ignored);
  endtask

  task automatic wb_read(input iadc_pkg::reg_idx_e idx, output logic [15:0] rdat);
    bus_cycle(1'b0, idx, 16'h0000, 2'b11, rdat);
  endtask

  // polls the status register until one flag reaches the wanted level
  task automatic wait_status(input int flag, input logic val, input string what);
    logic [15:0] st;
    int          tries;
    tries = 0;
    wb_read(iadc_pkg::REG_FIFO_STATUS, st);
    while (st[flag] !== val && tries < 100) begin
      tries++;
      wb_read(iadc_pkg::REG_FIFO_STATUS, st);
    end
    if (st[flag] !== val)
      log_failure(what);
  endtask

  task automatic read_head(output iadc_pkg::adc_sample_t w);
    logic [79:0] acc;
    logic [15:0] slice;
    acc = '0;
    for (int i = 0; i < 5; i++) begin
      wb_read(iadc_pkg::reg_idx_e'(int'(iadc_pkg::REG_FIFODATA_4) + i), slice);
      acc = {acc[63:0], slice};
    end
    w = acc[71:0];
  endtask

  // reads and pops until empty, each word must follow the previous sample number
  task automatic drain_fifo(output int words, output logic [31:0] first_n);
    iadc_pkg::adc_sample_t  w;
    iadc_pkg::fifo_status_t st;
    logic [15:0]            rd;
    words   = 0;
    first_n = '0;
    wb_read(iadc_pkg::REG_FIFO_STATUS, rd);
    st = rd[3:0];
    while (!st.empty && words <= DEPTH) begin
      read_head(w);
      if (words == 0)
        first_n = w.data[63:32]; // run starts wherever capture began
      checks++;
      if (w !== ref_sample(first_n + words))
        log_mismatch(ref_sample(first_n + words), w);
      wb_write(iadc_pkg::REG_FIFO_ADV, 16'h0001, 2'b01);
      words++;
      wb_read(iadc_pkg::REG_FIFO_STATUS, rd);
      st = rd[3:0];
    end
  endtask

  initial begin
    logic [15:0]            rd, wd;
    logic [15:0]            shadow [4];
    logic [1:0]             sel;
    logic [19:0]            got;
    iadc_pkg::twi_cmd_t     cmd;
    iadc_pkg::adc_sample_t  w;
    iadc_pkg::fifo_status_t exp_st;
    logic [31:0]            stale_n, first_n;
    int                     words, waited, tries;

    wb_rst_i    = 1'b1;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_sel_i    = 2'b00;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    {adc_sync_i, adc_oor_i, adc_data_i} = ref_sample(0);
    rng         = LFSR_SEED;
    ddrb_clocks = 0;
    checks      = 0;
    fails       = 0;
    rw_regs     = '{iadc_pkg::REG_MODE, iadc_pkg::REG_TWI_ADDR,
                    iadc_pkg::REG_TWI_DATA, iadc_pkg::REG_FIFO_CTRL};
    repeat (2) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    begin_test("readback");
    for (int k = 0; k < 4; k++) begin
      wb_read(rw_regs[k], rd);
      shadow[k] = '0;
      checks++;
      if (rd !== 16'h0000)
        log_mismatch(16'h0000, rd);
    end
    for (int k = 0; k < 4; k++) begin
      for (int j = 0; j < 3; j++) begin
        sel = (j == 0) ? 2'b11 : 2'(j); // both lanes, low only, high only
        wd  = 16'(take_bits(rng, 16));
        wb_write(rw_regs[k], wd, sel);
        shadow[k] = merge_write(shadow[k], wd, sel, field_mask(rw_regs[k]));
        wb_read(rw_regs[k], rd);
        checks++;
        if (rd !== shadow[k])
          log_mismatch(shadow[k], rd);
      end
    end
    wb_write(iadc_pkg::REG_FIFO_CTRL, 16'h0000, 2'b01); // capture off again
    end_test();

    begin_test("reset_pulse");
    ddrb_clocks = 0;
    wb_write(iadc_pkg::REG_RESET, 16'h0001, 2'b11);
    repeat (4) @(negedge wb_clk_i);
    checks++;
    if (ddrb_at_ack !== 1'b1)
      log_mismatch(1, ddrb_at_ack);
    wb_write(iadc_pkg::REG_RESET, 16'h0000, 2'b11);
    repeat (4) @(negedge wb_clk_i);
    checks++;
    if (ddrb_clocks != 1)
      log_mismatch(1, ddrb_clocks);
    for (int v = 1; v >= 0; v--) begin
      wb_write(iadc_pkg::REG_MODE, 16'(v), 2'b01);
      checks++;
      if (adc_mode_o !== v[0])
        log_mismatch(v[0], adc_mode_o);
    end
    end_test();

    begin_test("serial");
    for (int t = 0; t < 3; t++) begin
      cmd.addr = 3'(take_bits(rng, 3));
      cmd.data = 16'(take_bits(rng, 16));
      wb_write(iadc_pkg::REG_TWI_ADDR, 16'(cmd.addr), 2'b01);
      wb_write(iadc_pkg::REG_TWI_DATA, cmd.data, 2'b11);
      twi_bits_q.delete();
      wb_write(iadc_pkg::REG_TWI_TX, 16'h0001, 2'b01);
      wb_read(iadc_pkg::REG_TWI_TX, rd);
      checks++;
      if (rd !== 16'h0001)
        log_mismatch(16'h0001, rd);
      waited = 0;
      while (adc_ctrl_strobe_n_o !== 1'b1 && waited < 22 * BIT_CLKS) begin
        waited++;
        @(negedge wb_clk_i);
      end
      tries = 0;
      wb_read(iadc_pkg::REG_TWI_TX, rd);
      while (rd !== 16'h0000 && tries < BIT_CLKS) begin
        tries++;
        wb_read(iadc_pkg::REG_TWI_TX, rd);
      end
      if (adc_ctrl_strobe_n_o !== 1'b1 || rd !== 16'h0000)
        log_failure("serial transfer never finished");
      got = '0;
      foreach (twi_bits_q[i])
        got = {got[18:0], twi_bits_q[i]};
      checks++;
      if (twi_bits_q.size() != 20)
        log_mismatch(20, twi_bits_q.size());
      checks++;
      if (got !== twi_expect(cmd))
        log_mismatch(twi_expect(cmd), got);
    end
    end_test();

    begin_test("fill_drain");
    wb_write(iadc_pkg::REG_FIFO_CTRL, 16'h0001, 2'b01);
    wait_status(3, 1'b1, "fifo never reported full");
    wb_read(iadc_pkg::REG_FIFO_STATUS, rd);
    exp_st = '{full: 1'b1, almost_full: 1'b1, almost_empty: 1'b0, empty: 1'b0};
    checks++;
    if (rd !== 16'(exp_st))
      log_mismatch(16'(exp_st), rd);
    wb_write(iadc_pkg::REG_FIFO_CTRL, 16'h0000, 2'b01);
    drain_fifo(words, first_n);
    checks++;
    if (words != DEPTH)
      log_mismatch(DEPTH, words);
    wb_read(iadc_pkg::REG_FIFO_STATUS, rd);
    exp_st = '{full: 1'b0, almost_full: 1'b0, almost_empty: 1'b1, empty: 1'b1};
    checks++;
    if (rd !== 16'(exp_st))
      log_mismatch(16'(exp_st), rd);
    end_test();

    begin_test("clear_on_enable");
    wb_write(iadc_pkg::REG_FIFO_CTRL, 16'h0001, 2'b01);
    wait_status(0, 1'b0, "no sample captured");
    wb_write(iadc_pkg::REG_FIFO_CTRL, 16'h0000, 2'b01);
    read_head(w);                                       // stale word stays in place
    stale_n = w.data[63:32];
    checks++;
    if (w !== ref_sample(stale_n))
      log_mismatch(ref_sample(stale_n), w);
    wb_write(iadc_pkg::REG_FIFO_CTRL, 16'h0000, 2'b01);
    wb_write(iadc_pkg::REG_FIFO_CTRL, 16'h0001, 2'b01); // rising enable discards it
    wait_status(0, 1'b0, "no sample captured after re-enable");
    wb_write(iadc_pkg::REG_FIFO_CTRL, 16'h0000, 2'b01);
    drain_fifo(words, first_n);
    if (words == 0)
      log_failure("nothing left to drain after re-enable");
    if (words != 0 && first_n <= stale_n)
      log_failure($sformatf("drained run starts at %0d, not after stale %0d", first_n, stale_n));
    end_test();

    $display("checks passed %0d failed %0d", checks - fails, fails);
    if (fails == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
+incdir+tests
source/iadc_pkg.sv
source/iadc_regs.sv
source/twi_clk_div.sv
source/twi_fsm.sv
source/capture_fifo.sv
source/iadc_top.sv
tests/tb_iadc.sv
